// ==== bench/mem_stim.txt ====
// op size addr data expected; op 0 fetch, 1 load, 2 store, 3 fetch and load together
// size 0 byte, 1 half, 2 word; for op 3 the data column is the word the fetch expects
2 2 00000000 11223344 00000000
2 2 00000004 55667788 00000000
2 2 00000008 a1b2c3d4 00000000
2 2 0000000c 8090a0b0 00000000
2 2 00000010 00000000 00000000
2 2 00000014 ffffffff 00000000
2 2 00000100 13579bdf 00000000
2 2 00000104 2468ace0 00000000
2 2 00001ffc cafef00d 00000000
2 2 00000ff8 0badf00d 00000000
1 2 00000000 00000000 11223344
1 2 00000ffc 00000000 cafef00d
1 2 00001ff8 00000000 0badf00d
2 0 00000011 000000a5 00000000
2 1 00000012 00008001 00000000
1 2 00000010 00000000 8001a500
2 0 00000014 00000012 00000000
2 0 00000017 00000000 00000000
1 2 00000014 00000000 00ffff12
1 0 00000008 00000000 ffffffd4
1 0 0000000b 00000000 ffffffa1
1 0 00000000 00000000 00000044
1 0 00000002 00000000 00000022
1 0 00000012 00000000 00000001
1 1 00000008 00000000 ffffc3d4
1 1 00000000 00000000 00003344
1 1 0000000c 00000000 ffffa0b0
1 1 00000013 00000000 ffff8001
0 2 00000100 00000000 13579bdf
0 2 00000106 00000000 2468ace0
1 2 00000100 00000000 13579bdf
3 2 00000104 2468ace0 2468ace0
0 2 00000008 00000000 a1b2c3d4
3 0 0000000d 8090a0b0 ffffffa0
1 2 00000004 00000000 55667788
3 1 00000004 55667788 00007788
3 2 00000000 11223344 11223344

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/10ps

module mem_subsystem_tb;

    localparam int max_ops = 64;
    localparam int rec_words = 5;
    localparam int cycles_per_op = 20;
    localparam int reset_cycles = 16;
    // a contended read finishes well inside this
    localparam int done_wait_limit = 16;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  fetch_req;
    mem_sys_pkg::addr_t    fetch_addr;
    logic                  fetch_busy;
    logic                  fetch_valid;
    mem_sys_pkg::data_t    fetch_data;
    logic                  ls_req;
    logic                  ls_write;
    mem_sys_pkg::ls_size_t ls_size;
    mem_sys_pkg::addr_t    ls_addr;
    mem_sys_pkg::data_t    ls_wdata;
    logic                  ls_busy;
    logic                  ls_done;
    mem_sys_pkg::data_t    ls_rdata;

    mem_sys_pkg::data_t stim [0:max_ops*rec_words-1];
    int                 num_ops;
    int                 cycle_limit = max_ops * cycles_per_op;
    int                 cycle_count = 0;
    logic [7:0]         lfsr_state = 8'd36;

    mem_subsystem_top mem_subsystem_top_inst (
        .clk(clk), .reset(reset),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_busy(fetch_busy),
        .fetch_valid(fetch_valid), .fetch_data(fetch_data),
        .ls_req(ls_req), .ls_write(ls_write), .ls_size(ls_size), .ls_addr(ls_addr),
        .ls_wdata(ls_wdata), .ls_busy(ls_busy), .ls_done(ls_done), .ls_rdata(ls_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 8'hb8;
        end
        return next;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_fetch(input mem_sys_pkg::data_t expected);
        if (fetch_data !== expected) begin
            $display("** Error at %0t ns: fetch_data is %h, expected %h",
                     $time, fetch_data, expected);
            abort_run();
        end
    endtask

    task automatic check_load(input mem_sys_pkg::data_t expected);
        if (ls_rdata !== expected) begin
            $display("** Error at %0t ns: ls_rdata is %h, expected %h",
                     $time, ls_rdata, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %b, expected %b",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // nothing outstanding, so no pulse and no busy
    task automatic expect_quiet();
        check_flag("fetch_valid", fetch_valid, 1'b0);
        check_flag("ls_done", ls_done, 1'b0);
        check_flag("fetch_busy", fetch_busy, 1'b0);
        check_flag("ls_busy", ls_busy, 1'b0);
    endtask

    // two LFSR bits give 0 to 3 idle cycles
    task automatic idle_gap();
        int gap;
        int bit_idx;
        gap = 0;
        for (bit_idx = 0; bit_idx < 2; bit_idx++) begin
            gap = (gap << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
            expect_quiet();
        end
    endtask

    task automatic issue(input logic do_fetch, input logic do_ls, input logic write,
                         input mem_sys_pkg::ls_size_t size, input mem_sys_pkg::addr_t addr,
                         input mem_sys_pkg::data_t wdata);
        @(posedge clk);
        #1;
        expect_quiet();
        fetch_req = do_fetch;
        fetch_addr = addr;
        ls_req = do_ls;
        ls_write = write;
        ls_size = size;
        ls_addr = addr;
        ls_wdata = wdata;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
        ls_req = 1'b0;
        // an accepted request makes its port busy
        check_flag("fetch_busy", fetch_busy, do_fetch);
        check_flag("ls_busy", ls_busy, do_ls);
    endtask

    // each port may pulse once, and only when it has a request out
    task automatic wait_done(input logic want_fetch, input logic want_ls, input logic ls_load,
                             input mem_sys_pkg::data_t fetch_exp,
                             input mem_sys_pkg::data_t ls_exp);
        logic fetch_seen;
        logic ls_seen;
        int   waited;
        fetch_seen = 1'b0;
        ls_seen = 1'b0;
        waited = 0;
        while ((want_fetch && !fetch_seen) || (want_ls && !ls_seen)) begin
            if (waited >= done_wait_limit) begin
                $display("No done pulse arrived within %0d cycles, at %0t ns",
                         done_wait_limit, $time);
                abort_run();
            end
            @(posedge clk);
            #1;
            waited++;
            if (fetch_valid === 1'b1) begin
                if (!want_fetch || fetch_seen) begin
                    $display("fetch_valid pulsed with no fetch outstanding at %0t ns", $time);
                    abort_run();
                end
                check_fetch(fetch_exp);
                fetch_seen = 1'b1;
            end else if (want_fetch && !fetch_seen) begin
                check_flag("fetch_busy", fetch_busy, 1'b1);
            end
            if (ls_done === 1'b1) begin
                if (!want_ls || ls_seen) begin
                    $display("ls_done pulsed with no access outstanding at %0t ns", $time);
                    abort_run();
                end
                if (ls_load) begin
                    check_load(ls_exp);
                end
                ls_seen = 1'b1;
            end else if (want_ls && !ls_seen) begin
                check_flag("ls_busy", ls_busy, 1'b1);
            end
        end
    endtask

    task automatic run_op(input int idx);
        mem_sys_pkg::data_t    op;
        mem_sys_pkg::ls_size_t size;
        mem_sys_pkg::addr_t    addr;
        mem_sys_pkg::data_t    data;
        mem_sys_pkg::data_t    expected;
        op = stim[idx*rec_words];
        size = mem_sys_pkg::ls_size_t'(stim[idx*rec_words+1][1:0]);
        addr = stim[idx*rec_words+2];
        data = stim[idx*rec_words+3];
        expected = stim[idx*rec_words+4];
        idle_gap();
        case (op)
            32'd0: begin
                issue(1'b1, 1'b0, 1'b0, size, addr, data);
                wait_done(1'b1, 1'b0, 1'b0, expected, '0);
            end
            32'd1: begin
                issue(1'b0, 1'b1, 1'b0, size, addr, data);
                wait_done(1'b0, 1'b1, 1'b1, '0, expected);
            end
            32'd2: begin
                issue(1'b0, 1'b1, 1'b1, size, addr, data);
                wait_done(1'b0, 1'b1, 1'b0, '0, '0);
            end
            // fetch and load in the same cycle with the fetch word in the data column
            32'd3: begin
                issue(1'b1, 1'b1, 1'b0, size, addr, '0);
                wait_done(1'b1, 1'b1, 1'b1, data, expected);
            end
            default: begin
                $display("Unknown op code %h in stim record %0d", op, idx);
                abort_run();
            end
        endcase
    endtask

    initial begin
        int idx;
        reset = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        ls_req = 1'b0;
        ls_write = 1'b0;
        ls_size = mem_sys_pkg::ls_word;
        ls_addr = '0;
        ls_wdata = '0;
        for (idx = 0; idx < max_ops * rec_words; idx++) begin
            stim[idx] = 32'hffff_ffff;
        end
        $readmemh("bench/mem_stim.txt", stim);
        num_ops = 0;
        while (num_ops < max_ops && stim[num_ops*rec_words] !== 32'hffff_ffff) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            $display("No operations found in bench/mem_stim.txt");
            abort_run();
        end
        cycle_limit = num_ops * cycles_per_op;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
        // quiet outputs before the first request
        repeat (3) begin
            @(posedge clk);
            #1;
            expect_quiet();
        end
        for (idx = 0; idx < num_ops; idx++) begin
            run_op(idx);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/mem_sys_pkg.sv
logic/axi_lite_mem.sv
logic/fetch_bridge.sv
logic/lsu_bridge.sv
logic/read_arbiter.sv
logic/mem_subsystem_top.sv
bench/mem_subsystem_tb.sv

// ==== logic/axi_lite_mem.sv ====
`timescale 1ns/10ps

module axi_lite_mem (
    input  logic               clk,
    input  logic               reset,
    input  logic               ar_valid,
    output logic               ar_ready,
    input  mem_sys_pkg::addr_t ar_addr,
    output logic               rd_valid,
    input  logic               rd_ready,
    output mem_sys_pkg::data_t rd_data,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  mem_sys_pkg::addr_t aw_addr,
    input  logic               wd_valid,
    output logic               wd_ready,
    input  mem_sys_pkg::data_t wd_data,
    input  mem_sys_pkg::strb_t wstrb,
    output logic               wr_valid,
    input  logic               wr_ready
);

    mem_sys_pkg::chan_state_t read_state;
    mem_sys_pkg::chan_state_t read_next;
    mem_sys_pkg::chan_state_t write_state;
    mem_sys_pkg::chan_state_t write_next;

    mem_sys_pkg::data_t mem [0:mem_sys_pkg::mem_words-1];
    mem_sys_pkg::data_t rdata;

    logic [mem_sys_pkg::word_idx_w-1:0] read_idx;
    logic [mem_sys_pkg::word_idx_w-1:0] write_idx;
    logic ar_fire;
    logic aw_fire;

    // word index wraps modulo the depth
    assign read_idx = ar_addr[mem_sys_pkg::word_idx_w+1:2];
    assign write_idx = aw_addr[mem_sys_pkg::word_idx_w+1:2];

    assign ar_fire = ar_valid && ar_ready;
    // address and data are taken in the same cycle
    assign aw_fire = aw_valid && wd_valid && aw_ready && wd_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            read_state <= mem_sys_pkg::chan_idle;
            write_state <= mem_sys_pkg::chan_idle;
        end else begin
            read_state <= read_next;
            write_state <= write_next;
        end
    end

    always_comb begin
        read_next = read_state;
        if (read_state == mem_sys_pkg::chan_idle) begin
            if (ar_fire) begin
                read_next = mem_sys_pkg::chan_resp;
            end
        end else if (rd_valid && rd_ready) begin
            read_next = mem_sys_pkg::chan_idle;
        end
    end

    always_comb begin
        write_next = write_state;
        if (write_state == mem_sys_pkg::chan_idle) begin
            if (aw_fire) begin
                write_next = mem_sys_pkg::chan_resp;
            end
        end else if (wr_valid && wr_ready) begin
            write_next = mem_sys_pkg::chan_idle;
        end
    end

    // read word captured at the address transfer
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= mem[read_idx];
        end
    end

    // byte-lane write
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            for (int lane = 0; lane < mem_sys_pkg::strb_w; lane++) begin
                if (wstrb[lane]) begin
                    mem[write_idx][lane*8 +: 8] <= wd_data[lane*8 +: 8];
                end
            end
        end
    end

    assign rd_data = rdata;
    assign ar_ready = (read_state == mem_sys_pkg::chan_idle);
    assign rd_valid = (read_state == mem_sys_pkg::chan_resp);
    assign aw_ready = (write_state == mem_sys_pkg::chan_idle);
    assign wd_ready = (write_state == mem_sys_pkg::chan_idle);
    assign wr_valid = (write_state == mem_sys_pkg::chan_resp);

endmodule

// ==== logic/fetch_bridge.sv ====
`timescale 1ns/10ps

module fetch_bridge (
    input  logic               clk,
    input  logic               reset,
    input  logic               fetch_req,
    input  mem_sys_pkg::addr_t fetch_addr,
    output logic               fetch_busy,
    output logic               fetch_valid,
    output mem_sys_pkg::data_t fetch_data,
    output logic               ar_valid,
    input  logic               ar_ready,
    output mem_sys_pkg::addr_t ar_addr,
    input  logic               rd_valid,
    output logic               rd_ready,
    input  mem_sys_pkg::data_t rd_data
);

    mem_sys_pkg::bridge_state_t state;
    mem_sys_pkg::addr_t addr_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= mem_sys_pkg::br_idle;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                mem_sys_pkg::br_idle: begin
                    if (fetch_req) begin
                        state <= mem_sys_pkg::br_addr;
                    end
                end
                mem_sys_pkg::br_addr: begin
                    if (ar_ready) begin
                        state <= mem_sys_pkg::br_wait;
                    end
                end
                mem_sys_pkg::br_wait: begin
                    if (rd_valid) begin
                        state <= mem_sys_pkg::br_idle;
                        fetch_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= mem_sys_pkg::br_idle;
                end
            endcase
        end
    end

    // instructions are whole words
    always_ff @(posedge clk) begin
        if (state == mem_sys_pkg::br_idle && fetch_req) begin
            addr_q <= {fetch_addr[mem_sys_pkg::addr_w-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_sys_pkg::br_wait && rd_valid) begin
            fetch_data <= rd_data;
        end
    end

    assign ar_addr = addr_q;
    assign ar_valid = (state == mem_sys_pkg::br_addr);
    assign rd_ready = (state == mem_sys_pkg::br_wait);
    assign fetch_busy = (state != mem_sys_pkg::br_idle);

endmodule

// ==== logic/lsu_bridge.sv ====
`timescale 1ns/10ps

module lsu_bridge (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ls_req,
    input  logic                  ls_write,
    input  mem_sys_pkg::ls_size_t ls_size,
    input  mem_sys_pkg::addr_t    ls_addr,
    input  mem_sys_pkg::data_t    ls_wdata,
    output logic                  ls_busy,
    output logic                  ls_done,
    output mem_sys_pkg::data_t    ls_rdata,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output mem_sys_pkg::addr_t    ar_addr,
    input  logic                  rd_valid,
    output logic                  rd_ready,
    input  mem_sys_pkg::data_t    rd_data,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output mem_sys_pkg::addr_t    aw_addr,
    output logic                  wd_valid,
    input  logic                  wd_ready,
    output mem_sys_pkg::data_t    wd_data,
    output mem_sys_pkg::strb_t    wstrb,
    input  logic                  wr_valid,
    output logic                  wr_ready
);

    mem_sys_pkg::bridge_state_t state;
    logic                       write_q;
    mem_sys_pkg::ls_size_t      size_q;
    mem_sys_pkg::addr_t         addr_q;
    mem_sys_pkg::data_t         wdata_q;
    logic [7:0]                 byte_lane;
    logic [15:0]                half_lane;
    mem_sys_pkg::data_t         load_ext;
    logic                       resp_fire;

    assign resp_fire = write_q ? wr_valid : rd_valid;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= mem_sys_pkg::br_idle;
            ls_done <= 1'b0;
        end else begin
            ls_done <= 1'b0;
            case (state)
                mem_sys_pkg::br_idle: begin
                    if (ls_req) begin
                        state <= mem_sys_pkg::br_addr;
                    end
                end
                mem_sys_pkg::br_addr: begin
                    if (write_q ? (aw_ready && wd_ready) : ar_ready) begin
                        state <= mem_sys_pkg::br_wait;
                    end
                end
                mem_sys_pkg::br_wait: begin
                    if (resp_fire) begin
                        state <= mem_sys_pkg::br_idle;
                        ls_done <= 1'b1;
                    end
                end
                default: begin
                    state <= mem_sys_pkg::br_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_sys_pkg::br_idle && ls_req) begin
            write_q <= ls_write;
            size_q <= ls_size;
            addr_q <= ls_addr;
            wdata_q <= ls_wdata;
        end
    end

    // lane replication and strobes for stores
    always_comb begin
        case (size_q)
            mem_sys_pkg::ls_byte: begin
                wd_data = {4{wdata_q[7:0]}};
                wstrb = 4'b0001 << addr_q[1:0];
            end
            mem_sys_pkg::ls_half: begin
                wd_data = {2{wdata_q[15:0]}};
                wstrb = addr_q[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wd_data = wdata_q;
                wstrb = 4'b1111;
            end
        endcase
    end

    // lane select and sign extension for loads
    always_comb begin
        byte_lane = rd_data[{addr_q[1:0], 3'b000} +: 8];
        half_lane = addr_q[1] ? rd_data[31:16] : rd_data[15:0];
        case (size_q)
            mem_sys_pkg::ls_byte: load_ext = {{24{byte_lane[7]}}, byte_lane};
            mem_sys_pkg::ls_half: load_ext = {{16{half_lane[15]}}, half_lane};
            default: load_ext = rd_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == mem_sys_pkg::br_wait && !write_q && rd_valid) begin
            ls_rdata <= load_ext;
        end
    end

    assign ar_addr = {addr_q[mem_sys_pkg::addr_w-1:2], 2'b00};
    assign aw_addr = {addr_q[mem_sys_pkg::addr_w-1:2], 2'b00};
    assign ar_valid = (state == mem_sys_pkg::br_addr) && !write_q;
    assign aw_valid = (state == mem_sys_pkg::br_addr) && write_q;
    assign wd_valid = (state == mem_sys_pkg::br_addr) && write_q;
    assign rd_ready = (state == mem_sys_pkg::br_wait) && !write_q;
    assign wr_ready = (state == mem_sys_pkg::br_wait) && write_q;
    assign ls_busy = (state != mem_sys_pkg::br_idle);

endmodule

// ==== logic/mem_subsystem_top.sv ====
`timescale 1ns/10ps

module mem_subsystem_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_req,
    input  mem_sys_pkg::addr_t    fetch_addr,
    output logic                  fetch_busy,
    output logic                  fetch_valid,
    output mem_sys_pkg::data_t    fetch_data,
    input  logic                  ls_req,
    input  logic                  ls_write,
    input  mem_sys_pkg::ls_size_t ls_size,
    input  mem_sys_pkg::addr_t    ls_addr,
    input  mem_sys_pkg::data_t    ls_wdata,
    output logic                  ls_busy,
    output logic                  ls_done,
    output mem_sys_pkg::data_t    ls_rdata
);

    // fetch read master
    logic               f_ar_valid;
    logic               f_ar_ready;
    mem_sys_pkg::addr_t f_ar_addr;
    logic               f_rd_valid;
    logic               f_rd_ready;

    // load/store read master
    logic               l_ar_valid;
    logic               l_ar_ready;
    mem_sys_pkg::addr_t l_ar_addr;
    logic               l_rd_valid;
    logic               l_rd_ready;

    // arbitrated read channels into the memory
    logic               m_ar_valid;
    logic               m_ar_ready;
    mem_sys_pkg::addr_t m_ar_addr;
    logic               m_rd_valid;
    logic               m_rd_ready;
    mem_sys_pkg::data_t m_rd_data;

    // store path goes straight to the memory
    logic               aw_valid;
    logic               aw_ready;
    mem_sys_pkg::addr_t aw_addr;
    logic               wd_valid;
    logic               wd_ready;
    mem_sys_pkg::data_t wd_data;
    mem_sys_pkg::strb_t wstrb;
    logic               wr_valid;
    logic               wr_ready;

    fetch_bridge fetch_bridge_inst (
        .clk(clk), .reset(reset),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_busy(fetch_busy),
        .fetch_valid(fetch_valid), .fetch_data(fetch_data),
        .ar_valid(f_ar_valid), .ar_ready(f_ar_ready), .ar_addr(f_ar_addr),
        .rd_valid(f_rd_valid), .rd_ready(f_rd_ready), .rd_data(m_rd_data)
    );

    lsu_bridge lsu_bridge_inst (
        .clk(clk), .reset(reset),
        .ls_req(ls_req), .ls_write(ls_write), .ls_size(ls_size), .ls_addr(ls_addr),
        .ls_wdata(ls_wdata), .ls_busy(ls_busy), .ls_done(ls_done), .ls_rdata(ls_rdata),
        .ar_valid(l_ar_valid), .ar_ready(l_ar_ready), .ar_addr(l_ar_addr),
        .rd_valid(l_rd_valid), .rd_ready(l_rd_ready), .rd_data(m_rd_data),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .wd_valid(wd_valid), .wd_ready(wd_ready), .wd_data(wd_data), .wstrb(wstrb),
        .wr_valid(wr_valid), .wr_ready(wr_ready)
    );

    read_arbiter read_arbiter_inst (
        .clk(clk), .reset(reset),
        .f_ar_valid(f_ar_valid), .f_ar_ready(f_ar_ready), .f_ar_addr(f_ar_addr),
        .f_rd_valid(f_rd_valid), .f_rd_ready(f_rd_ready),
        .l_ar_valid(l_ar_valid), .l_ar_ready(l_ar_ready), .l_ar_addr(l_ar_addr),
        .l_rd_valid(l_rd_valid), .l_rd_ready(l_rd_ready),
        .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready), .m_ar_addr(m_ar_addr),
        .m_rd_valid(m_rd_valid), .m_rd_ready(m_rd_ready)
    );

    axi_lite_mem axi_lite_mem_inst (
        .clk(clk), .reset(reset),
        .ar_valid(m_ar_valid), .ar_ready(m_ar_ready), .ar_addr(m_ar_addr),
        .rd_valid(m_rd_valid), .rd_ready(m_rd_ready), .rd_data(m_rd_data),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .wd_valid(wd_valid), .wd_ready(wd_ready), .wd_data(wd_data), .wstrb(wstrb),
        .wr_valid(wr_valid), .wr_ready(wr_ready)
    );

endmodule

// ==== logic/mem_sys_pkg.sv ====
package mem_sys_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // word array depth and its index width
    localparam int mem_words = 1024;
    localparam int word_idx_w = $clog2(mem_words);

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;

    // per-channel state of the memory slave
    typedef enum logic {
        chan_idle = 1'b0,
        chan_resp = 1'b1
    } chan_state_t;

    // shared by the fetch and load/store bridges
    typedef enum logic [1:0] {
        br_idle = 2'd0,
        br_addr = 2'd1,
        br_wait = 2'd2
    } bridge_state_t;

    // load/store access size
    typedef enum logic [1:0] {
        ls_byte = 2'd0,
        ls_half = 2'd1,
        ls_word = 2'd2
    } ls_size_t;

    // read channel owner in the arbiter
    typedef enum logic {
        own_fetch = 1'b0,
        own_lsu   = 1'b1
    } rd_owner_t;

endpackage

// ==== logic/read_arbiter.sv ====
`timescale 1ns/10ps

module read_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               f_ar_valid,
    output logic               f_ar_ready,
    input  mem_sys_pkg::addr_t f_ar_addr,
    output logic               f_rd_valid,
    input  logic               f_rd_ready,
    input  logic               l_ar_valid,
    output logic               l_ar_ready,
    input  mem_sys_pkg::addr_t l_ar_addr,
    output logic               l_rd_valid,
    input  logic               l_rd_ready,
    output logic               m_ar_valid,
    input  logic               m_ar_ready,
    output mem_sys_pkg::addr_t m_ar_addr,
    input  logic               m_rd_valid,
    output logic               m_rd_ready
);

    mem_sys_pkg::rd_owner_t grant;
    mem_sys_pkg::rd_owner_t owner;
    mem_sys_pkg::rd_owner_t last_win;
    logic                   busy;
    logic                   ar_fire;
    logic                   rd_fire;

    // on a tie the master that lost last time wins
    always_comb begin
        if (f_ar_valid && l_ar_valid) begin
            if (last_win == mem_sys_pkg::own_fetch) begin
                grant = mem_sys_pkg::own_lsu;
            end else begin
                grant = mem_sys_pkg::own_fetch;
            end
        end else if (l_ar_valid) begin
            grant = mem_sys_pkg::own_lsu;
        end else begin
            grant = mem_sys_pkg::own_fetch;
        end
    end

    // no new address while a read is outstanding
    assign m_ar_valid = !busy && (f_ar_valid || l_ar_valid);
    assign m_ar_addr = (grant == mem_sys_pkg::own_lsu) ? l_ar_addr : f_ar_addr;
    assign f_ar_ready = !busy && (grant == mem_sys_pkg::own_fetch) && m_ar_ready;
    assign l_ar_ready = !busy && (grant == mem_sys_pkg::own_lsu) && m_ar_ready;

    assign f_rd_valid = busy && (owner == mem_sys_pkg::own_fetch) && m_rd_valid;
    assign l_rd_valid = busy && (owner == mem_sys_pkg::own_lsu) && m_rd_valid;
    assign m_rd_ready = busy && ((owner == mem_sys_pkg::own_lsu) ? l_rd_ready : f_rd_ready);

    assign ar_fire = m_ar_valid && m_ar_ready;
    assign rd_fire = m_rd_valid && m_rd_ready;

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
            owner <= mem_sys_pkg::own_fetch;
            last_win <= mem_sys_pkg::own_lsu;
        end else begin
            if (ar_fire) begin
                busy <= 1'b1;
                owner <= grant;
                last_win <= grant;
            end else if (rd_fire) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module mem_subsystem_tb -f compile.f -o sim_bin

# the log decides the result, tee keeps the pipeline going on a failing run
./obj_dir/sim_bin | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failure"
